// File: idControl.f
src/idCtrlPkg.sv
src/aluDecode.sv
src/memDecode.sv
src/branchResolve.sv
src/exceptionSelect.sv
src/idControl.sv
testbench/tbClock.sv
testbench/idControl_checker.sv
testbench/idControlTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP      = idControlTb
FILELIST = idControl.f
SIMARGS  = +verilator+error+limit+1000
LOG      = sim.log
FAILMSG  = Something failed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# an aborted run counts as a failure
run: build
	./obj_dir/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || echo "$(FAILMSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAILMSG)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/idControlTb.sv
`timescale 1ns/10ps

module idControlTb import idCtrlPkg::*; ();

	localparam logic [5:0] opSpecial2 = 6'b011100;
	localparam int numDirected = 49;
	localparam int numRandom = 200;
	localparam int numChecks = 10;
	localparam logic [5:0] memOps [8] = '{opLb, opLhu, opLw, opLwl, opSb, opSwr, opLl, opSc};

	logic clk;
	logic rst;
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic cmpEqual;
	signClassT cmpSign;
	logic prevException;
	excCodeT prevExcCode;
	logic ifFlush;
	logic rfWr, shamtSrc, immSrc, dmRd, dmWr, llOp, scOp, isBranch, exception;
	regDstT regDst;
	wbSelT wbSel;
	aluOpT aluOp;
	extOpT extOp;
	memSizeT memSize;
	partialT loadPartial, storePartial;
	npcOpT npcOp;
	brTypeT brType;
	jTypeT jType;
	excCodeT excCode;

	logic [15:0] lfsr = 16'd47;
	int missCount;

	tbClock clkGen (.clk(clk));

	idControl UUT (.*);

	bind idControl idControl_checker chk (.*);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic string checkName(input int idx);
		case (idx)
			0: return "ALU decode";
			1: return "memory decode";
			2: return "next-PC resolution";
			3: return "return predictor type";
			4: return "fetch exception pass-through";
			5: return "syscall exception";
			6: return "breakpoint exception";
			7: return "flush suppressing reserved";
			8: return "reset window suppressing reserved";
			default: return "reserved after reset window";
		endcase
	endfunction

	task automatic applyVector(input logic [5:0] opIn, input logic [5:0] functIn,
			input logic [4:0] rsIn, input logic [4:0] rtIn, input logic flushIn,
			input logic excIn);
		logic [1:0] signBits;
		@(posedge clk);
		#1;
		// only three sign classes exist
		signBits = 2'(randBits(2));
		if (signBits == 2'b11)
			signBits = 2'b00;
		op = opIn;
		funct = functIn;
		rs = rsIn;
		rt = rtIn;
		cmpEqual = 1'(randBits(1));
		cmpSign = signClassT'(signBits);
		ifFlush = flushIn;
		prevException = excIn;
		prevExcCode = 5'(randBits(5));
	endtask

	task automatic applyOp(input logic [5:0] opIn, input logic [5:0] functIn);
		applyVector(opIn, functIn, 5'(randBits(5)), 5'(randBits(5)), 1'b0, 1'b0);
	endtask

	initial begin
		#((8 + numDirected + numRandom + 20) * 100);
		$display("watchdog timeout, stimulus did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		rst = 1'b0;
		op = opSpecial2;
		funct = '0;
		rs = '0;
		rt = '0;
		cmpEqual = 1'b0;
		cmpSign = signZero;
		prevException = 1'b0;
		prevExcCode = '0;
		ifFlush = 1'b0;
		// reserved opcode sits on the bus through reset and two cycles after
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		applyOp(opSpecial2, 6'(randBits(6)));
		applyOp(opSpecial2, 6'(randBits(6)));

		applyOp(opRType, fnAddu);
		applyOp(opRType, fnSll);
		applyOp(opAddi, 6'(randBits(6)));
		applyOp(opOri, 6'(randBits(6)));
		applyOp(opLui, 6'(randBits(6)));

		for (int i = 0; i < 8; i++)
			applyOp(memOps[i], 6'(randBits(6)));

		repeat (4) begin
			applyOp(opBeq, 6'(randBits(6)));
			applyOp(opBne, 6'(randBits(6)));
			applyOp(opBlez, 6'(randBits(6)));
			applyOp(opBgtz, 6'(randBits(6)));
			applyVector(opRegImm, 6'(randBits(6)), 5'(randBits(5)), rtBgez, 1'b0, 1'b0);
			applyVector(opRegImm, 6'(randBits(6)), 5'(randBits(5)), rtBltz, 1'b0, 1'b0);
		end
		applyOp(opJ, 6'(randBits(6)));
		applyOp(opRType, fnJr);
		applyVector(opRType, fnJr, raReg, 5'(randBits(5)), 1'b0, 1'b0);
		applyOp(opRType, fnJalr);

		applyVector(6'(randBits(6)), 6'(randBits(6)), 5'(randBits(5)), 5'(randBits(5)), 1'b0, 1'b1);
		applyVector(opSpecial2, 6'(randBits(6)), 5'(randBits(5)), 5'(randBits(5)), 1'b0, 1'b1);
		applyOp(opRType, fnSyscall);
		applyOp(opRType, fnBreak);
		applyOp(opSpecial2, 6'(randBits(6)));
		applyVector(opSpecial2, 6'(randBits(6)), 5'(randBits(5)), 5'(randBits(5)), 1'b1, 1'b0);

		repeat (numRandom)
			applyOp(6'(randBits(6)), 6'(randBits(6)));

		// let the last vector be sampled
		@(posedge clk);
		#1;
		for (int i = 0; i < numChecks; i++) begin
			if (UUT.chk.hits[i] == 0) begin
				$display("behavior %s was never reached by the stimulus", checkName(i));
				missCount++;
			end
		end
		$display("assertion failures %0d, unreached behaviors %0d", UUT.chk.failTotal, missCount);
		if (UUT.chk.failTotal == 0 && missCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: testbench/idControl_checker.sv
`timescale 1ns/10ps

module idControl_checker import idCtrlPkg::*; (
	input logic       clk,
	input logic       rst,
	input logic [5:0] op,
	input logic [5:0] funct,
	input logic [4:0] rs,
	input logic [4:0] rt,
	input logic       cmpEqual,
	input signClassT  cmpSign,
	input logic       prevException,
	input excCodeT    prevExcCode,
	input logic       ifFlush,
	input logic       rfWr,
	input regDstT     regDst,
	input wbSelT      wbSel,
	input aluOpT      aluOp,
	input logic       shamtSrc,
	input logic       immSrc,
	input extOpT      extOp,
	input logic       dmRd,
	input logic       dmWr,
	input memSizeT    memSize,
	input partialT    loadPartial,
	input partialT    storePartial,
	input logic       llOp,
	input logic       scOp,
	input logic       isBranch,
	input npcOpT      npcOp,
	input brTypeT     brType,
	input jTypeT      jType,
	input logic       exception,
	input excCodeT    excCode
);

	// SPECIAL2 holds the dropped multiply group
	localparam logic [5:0] opSpecial2 = 6'b011100;

	logic aluCase;
	logic memCase;
	logic brCase;
	logic [10:0] aluGot, aluExp, aluMask;
	logic [12:0] memGot, memExp, memMask;
	npcOpT npcExp;
	jTypeT jExp;
	logic [5:0] excGot;
	logic resvOp;
	logic [9:0] caseVec;
	logic windowRef = 1'b1;
	logic windowKnown = 1'b0;
	int hits [10];
	int aluFails, memFails, npcFails, retFails, passFails;
	int sysFails, brkFails, flushFails, windowFails, resvFails;
	int failTotal;

	function automatic npcOpT branchNpc(input logic cond);
		return cond ? npcBranch : npcSeq;
	endfunction

	assign aluGot = {rfWr, regDst, aluOp, extOp, immSrc, shamtSrc};

	// extOp is free for R-type, aluOp is free for LUI
	always_comb begin
		aluCase = 1'b1;
		aluMask = 11'h7ff;
		aluExp = '0;
		if (op == opRType && funct == fnAddu) begin
			aluMask = 11'h7f3;
			aluExp = {1'b1, dstRd, aluAddu, extZero, 2'b00};
		end else if (op == opRType && funct == fnSll) begin
			aluMask = 11'h7f3;
			aluExp = {1'b1, dstRd, aluSll, extZero, 2'b01};
		end else if (op == opAddi)
			aluExp = {1'b1, dstRt, aluAdd, extSign, 2'b10};
		else if (op == opOri)
			aluExp = {1'b1, dstRt, aluOr, extZero, 2'b10};
		else if (op == opLui) begin
			aluMask = 11'h70f;
			aluExp = {1'b1, dstRt, 4'h0, extUpper, 2'b10};
		end else
			aluCase = 1'b0;
	end

	assign memGot = {dmRd, dmWr, memSize, loadPartial, storePartial, llOp, scOp, wbSel};

	// write-back source only matters for loads and SC
	always_comb begin
		memCase = 1'b1;
		memMask = 13'h1fff;
		case (op)
			opLb: memExp = {2'b10, sizeByte, partNone, partNone, 2'b00, wbMem};
			opLhu: memExp = {2'b10, sizeHalfU, partNone, partNone, 2'b00, wbMem};
			opLw: memExp = {2'b10, sizeWord, partNone, partNone, 2'b00, wbMem};
			opLwl: memExp = {2'b10, sizeWord, partLeft, partNone, 2'b00, wbMem};
			opLl: memExp = {2'b10, sizeWord, partNone, partNone, 2'b10, wbMem};
			opSc: memExp = {2'b01, sizeWord, partNone, partNone, 2'b01, wbSc};
			opSb: begin
				memMask = 13'h1ffc;
				memExp = {2'b01, sizeByte, partNone, partNone, 2'b00, wbAlu};
			end
			opSwr: begin
				memMask = 13'h1ffc;
				memExp = {2'b01, sizeWord, partNone, partRight, 2'b00, wbAlu};
			end
			default: begin
				memCase = 1'b0;
				memExp = '0;
			end
		endcase
	end

	// condition table for the six branch kinds, then the jumps
	always_comb begin
		brCase = 1'b1;
		npcExp = npcSeq;
		jExp = jNone;
		case (op)
			opBeq: npcExp = branchNpc(cmpEqual);
			opBne: npcExp = branchNpc(!cmpEqual);
			opBlez: npcExp = branchNpc(cmpSign != signPos);
			opBgtz: npcExp = branchNpc(cmpSign == signPos);
			opJ: begin
				npcExp = npcJump;
				jExp = jDirect;
			end
			opRegImm: begin
				if (rt == rtBgez)
					npcExp = branchNpc(cmpSign != signNeg);
				else if (rt == rtBltz)
					npcExp = branchNpc(cmpSign == signNeg);
				else
					brCase = 1'b0;
			end
			opRType: begin
				if (funct == fnJr || funct == fnJalr) begin
					npcExp = npcJumpReg;
					jExp = jIndirect;
				end else
					brCase = 1'b0;
			end
			default: brCase = 1'b0;
		endcase
	end

	assign excGot = {exception, excCode};
	assign resvOp = (op == opSpecial2) && !prevException && windowKnown;

	assign caseVec = {
		resvOp && !ifFlush && !windowRef,
		resvOp && !ifFlush && windowRef,
		resvOp && ifFlush,
		!prevException && op == opRType && funct == fnBreak,
		!prevException && op == opRType && funct == fnSyscall,
		prevException,
		op == opRType && funct == fnJr && rs == raReg,
		brCase,
		memCase,
		aluCase
	};

	// window flag follows rst, set while low and for one edge past release
	always @(posedge clk) begin
		windowRef <= !rst;
		windowKnown <= 1'b1;
		for (int i = 0; i < 10; i++) begin
			if (caseVec[i])
				hits[i] <= hits[i] + 1;
		end
	end

	aluCheck: assert property (@(posedge clk) caseVec[0] |-> (aluGot & aluMask) == aluExp)
		else begin
			aluFails++;
			$error("error {rfWr,regDst,aluOp,extOp,immSrc,shamtSrc} %h, expected %h",
				aluGot & aluMask, aluExp);
		end

	memCheck: assert property (@(posedge clk) caseVec[1] |-> (memGot & memMask) == memExp)
		else begin
			memFails++;
			$error("error {dmRd,dmWr,memSize,loadPartial,storePartial,llOp,scOp,wbSel} %h, expected %h",
				memGot & memMask, memExp);
		end

	npcCheck: assert property (@(posedge clk)
		caseVec[2] |-> {isBranch, jType, npcOp} == {1'b1, jExp, npcExp})
		else begin
			npcFails++;
			$error("error {isBranch,jType,npcOp} %h, expected %h",
				{isBranch, jType, npcOp}, {1'b1, jExp, npcExp});
		end

	returnCheck: assert property (@(posedge clk) caseVec[3] |-> brType == brReturn)
		else begin
			retFails++;
			$error("error brType %h, expected %h", brType, brReturn);
		end

	passCheck: assert property (@(posedge clk) caseVec[4] |-> excGot == {1'b1, prevExcCode})
		else begin
			passFails++;
			$error("error {exception,excCode} %h, expected %h",
				$sampled(excGot), {1'b1, $sampled(prevExcCode)});
		end

	syscallCheck: assert property (@(posedge clk) caseVec[5] |-> excGot == {1'b1, excSyscall})
		else begin
			sysFails++;
			$error("error {exception,excCode} %h, expected %h", $sampled(excGot), {1'b1, excSyscall});
		end

	breakCheck: assert property (@(posedge clk) caseVec[6] |-> excGot == {1'b1, excBreak})
		else begin
			brkFails++;
			$error("error {exception,excCode} %h, expected %h", $sampled(excGot), {1'b1, excBreak});
		end

	flushCheck: assert property (@(posedge clk) caseVec[7] |-> excGot == {1'b0, excNone})
		else begin
			flushFails++;
			$error("error {exception,excCode} %h, expected %h", $sampled(excGot), {1'b0, excNone});
		end

	windowCheck: assert property (@(posedge clk) caseVec[8] |-> excGot == {1'b0, excNone})
		else begin
			windowFails++;
			$error("error {exception,excCode} %h, expected %h", $sampled(excGot), {1'b0, excNone});
		end

	reservedCheck: assert property (@(posedge clk) caseVec[9] |-> excGot == {1'b1, excReserved})
		else begin
			resvFails++;
			$error("error {exception,excCode} %h, expected %h",
				$sampled(excGot), {1'b1, excReserved});
		end

	assign failTotal = aluFails + memFails + npcFails + retFails + passFails
		+ sysFails + brkFails + flushFails + windowFails + resvFails;

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/10ps

module tbClock (
	output logic clk
);

	// 100 ns period
	initial clk = 1'b0;
	always #50 clk = !clk;

endmodule

// File: src/idControl.sv
`timescale 1ns/10ps

module idControl import idCtrlPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic [4:0] rs,
	input  logic [4:0] rt,
	input  logic       cmpEqual,
	input  signClassT  cmpSign,
	input  logic       prevException,
	input  excCodeT    prevExcCode,
	input  logic       ifFlush,
	output logic       rfWr,
	output regDstT     regDst,
	output wbSelT      wbSel,
	output aluOpT      aluOp,
	output logic       shamtSrc,
	output logic       immSrc,
	output extOpT      extOp,
	output logic       dmRd,
	output logic       dmWr,
	output memSizeT    memSize,
	output partialT    loadPartial,
	output partialT    storePartial,
	output logic       llOp,
	output logic       scOp,
	output logic       isBranch,
	output npcOpT      npcOp,
	output brTypeT     brType,
	output jTypeT      jType,
	output logic       exception,
	output excCodeT    excCode
);

	aluDecode uAlu (
		.op(op), .funct(funct), .rt(rt),
		.rfWr(rfWr), .regDst(regDst), .wbSel(wbSel), .aluOp(aluOp),
		.shamtSrc(shamtSrc), .immSrc(immSrc), .extOp(extOp)
	);

	memDecode uMem (
		.op(op), .dmRd(dmRd), .dmWr(dmWr), .memSize(memSize),
		.loadPartial(loadPartial), .storePartial(storePartial),
		.llOp(llOp), .scOp(scOp)
	);

	branchResolve uBranch (
		.op(op), .funct(funct), .rs(rs), .rt(rt),
		.cmpEqual(cmpEqual), .cmpSign(cmpSign),
		.isBranch(isBranch), .npcOp(npcOp), .brType(brType), .jType(jType)
	);

	// write enables and isBranch double as recognition terms
	exceptionSelect uExc (
		.clk(clk), .rst(rst), .op(op), .funct(funct),
		.rfWr(rfWr), .dmWr(dmWr), .isBranch(isBranch), .ifFlush(ifFlush),
		.prevException(prevException), .prevExcCode(prevExcCode),
		.exception(exception), .excCode(excCode)
	);

endmodule

// File: src/exceptionSelect.sv
`timescale 1ns/10ps

module exceptionSelect import idCtrlPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic       rfWr,
	input  logic       dmWr,
	input  logic       isBranch,
	input  logic       ifFlush,
	input  logic       prevException,
	input  excCodeT    prevExcCode,
	output logic       exception,
	output excCodeT    excCode
);

	logic rstWindow;
	logic isSyscall;
	logic isBreak;
	logic recognized;

	// held through reset and one cycle after release, while the pipe still holds junk
	always_ff @(posedge clk) begin
		if (!rst)
			rstWindow <= 1'b1;
		else
			rstWindow <= 1'b0;
	end

	assign isSyscall = (op == opRType) && (funct == fnSyscall);
	assign isBreak = (op == opRType) && (funct == fnBreak);

	// every supported instruction sets at least one of these terms
	assign recognized = rfWr || dmWr || isBranch || isSyscall || isBreak;

	always_comb begin
		exception = 1'b1;
		if (prevException)
			excCode = prevExcCode;
		else if (!recognized && !ifFlush && !rstWindow)
			excCode = excReserved;
		else if (isBreak)
			excCode = excBreak;
		else if (isSyscall)
			excCode = excSyscall;
		else begin
			exception = 1'b0;
			excCode = excNone;
		end
	end

endmodule

// File: src/branchResolve.sv
`timescale 1ns/10ps

module branchResolve import idCtrlPkg::*; (
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic [4:0] rs,
	input  logic [4:0] rt,
	input  logic       cmpEqual,
	input  signClassT  cmpSign,
	output logic       isBranch,
	output npcOpT      npcOp,
	output brTypeT     brType,
	output jTypeT      jType
);

	typedef enum logic [2:0] {
		condNone, condEq, condNe, condGez, condLtz, condLez, condGtz
	} condT;

	condT cond;
	logic taken;
	logic callBranch;

	// likely forms share the condition of the plain branch
	always_comb begin
		cond = condNone;
		case (op)
			opBeq, opBeql: cond = condEq;
			opBne, opBnel: cond = condNe;
			opBlez: cond = condLez;
			opBgtz: cond = condGtz;
			opBlezl: cond = (rt == 5'd0) ? condLez : condNone;
			opBgtzl: cond = (rt == 5'd0) ? condGtz : condNone;
			opRegImm: begin
				case (rt)
					rtBgez, rtBgezl, rtBgezal, rtBgezall: cond = condGez;
					rtBltz, rtBltzl, rtBltzal, rtBltzall: cond = condLtz;
					default: cond = condNone;
				endcase
			end
			default: ;
		endcase
	end

	always_comb begin
		case (cond)
			condEq: taken = cmpEqual;
			condNe: taken = !cmpEqual;
			condGez: taken = (cmpSign != signNeg);
			condLtz: taken = (cmpSign == signNeg);
			condLez: taken = (cmpSign != signPos);
			condGtz: taken = (cmpSign == signPos);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		jType = jNone;
		if (op == opJ || op == opJal)
			jType = jDirect;
		else if (op == opRType && (funct == fnJr || funct == fnJalr))
			jType = jIndirect;
	end

	assign isBranch = (cond != condNone) || (jType != jNone);

	always_comb begin
		if (cond != condNone)
			npcOp = taken ? npcBranch : npcSeq;
		else if (jType == jDirect)
			npcOp = npcJump;
		else if (jType == jIndirect)
			npcOp = npcJumpReg;
		else
			npcOp = npcSeq;
	end

	// predictor pushes the return stack on calls, pops on jr $ra
	assign callBranch = (op == opJal) || (op == opRegImm && (rt == rtBgezal || rt == rtBltzal));

	always_comb begin
		if (callBranch)
			brType = brCall;
		else if (op == opRType && funct == fnJr && rs == raReg)
			brType = brReturn;
		else if (isBranch)
			brType = brOther;
		else
			brType = brNone;
	end

endmodule

// File: src/memDecode.sv
`timescale 1ns/10ps

module memDecode import idCtrlPkg::*; (
	input  logic [5:0] op,
	output logic       dmRd,
	output logic       dmWr,
	output memSizeT    memSize,
	output partialT    loadPartial,
	output partialT    storePartial,
	output logic       llOp,
	output logic       scOp
);

	always_comb begin
		dmRd = 1'b0;
		dmWr = 1'b0;
		// unaligned and word accesses all move a full word
		memSize = sizeWord;
		loadPartial = partNone;
		storePartial = partNone;
		case (op)
			opLb: begin
				dmRd = 1'b1;
				memSize = sizeByte;
			end
			opLbu: begin
				dmRd = 1'b1;
				memSize = sizeByteU;
			end
			opLh: begin
				dmRd = 1'b1;
				memSize = sizeHalf;
			end
			opLhu: begin
				dmRd = 1'b1;
				memSize = sizeHalfU;
			end
			opLw, opLl: dmRd = 1'b1;
			opLwl: begin
				dmRd = 1'b1;
				loadPartial = partLeft;
			end
			opLwr: begin
				dmRd = 1'b1;
				loadPartial = partRight;
			end
			opSb: begin
				dmWr = 1'b1;
				memSize = sizeByte;
			end
			opSh: begin
				dmWr = 1'b1;
				memSize = sizeHalf;
			end
			opSw, opSc: dmWr = 1'b1;
			opSwl: begin
				dmWr = 1'b1;
				storePartial = partLeft;
			end
			opSwr: begin
				dmWr = 1'b1;
				storePartial = partRight;
			end
			default: ;
		endcase
	end

	assign llOp = (op == opLl);
	assign scOp = (op == opSc);

endmodule

// File: src/aluDecode.sv
`timescale 1ns/10ps

module aluDecode import idCtrlPkg::*; (
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic [4:0] rt,
	output logic       rfWr,
	output regDstT     regDst,
	output wbSelT      wbSel,
	output aluOpT      aluOp,
	output logic       shamtSrc,
	output logic       immSrc,
	output extOpT      extOp
);

	logic rTypeAlu;
	aluOpT rAluOp;
	logic linkBranch;

	// SPECIAL functions handled by the integer ALU
	always_comb begin
		rTypeAlu = 1'b1;
		case (funct)
			fnAdd: rAluOp = aluAdd;
			fnAddu: rAluOp = aluAddu;
			fnSub: rAluOp = aluSub;
			fnSubu: rAluOp = aluSubu;
			fnOr: rAluOp = aluOr;
			fnAnd: rAluOp = aluAnd;
			fnNor: rAluOp = aluNor;
			fnXor: rAluOp = aluXor;
			fnSll, fnSllv: rAluOp = aluSll;
			fnSrl, fnSrlv: rAluOp = aluSrl;
			fnSra, fnSrav: rAluOp = aluSra;
			fnSlt: rAluOp = aluSlt;
			fnSltu: rAluOp = aluSltu;
			default: begin
				rTypeAlu = 1'b0;
				rAluOp = aluNone;
			end
		endcase
	end

	// BGEZAL, BLTZAL and their likely forms write the return address
	assign linkBranch = (op == opRegImm) && rt[4] && (rt[3:2] == 2'b00);

	// constant shifts take the amount from the shamt field
	assign shamtSrc = (op == opRType) && (funct == fnSll || funct == fnSrl || funct == fnSra);
	assign immSrc = (op != opRType);

	always_comb begin
		rfWr = 1'b0;
		regDst = dstRt;
		wbSel = wbAlu;
		aluOp = aluNone;
		extOp = extZero;
		case (op)
			opRType: begin
				rfWr = rTypeAlu || (funct == fnJalr);
				regDst = dstRd;
				aluOp = rAluOp;
				if (funct == fnJalr)
					wbSel = wbLink;
			end
			opAddi, opAddiu, opSlti, opSltiu: begin
				rfWr = 1'b1;
				extOp = extSign;
				case (op)
					opAddi: aluOp = aluAdd;
					opAddiu: aluOp = aluAddu;
					opSlti: aluOp = aluSlt;
					default: aluOp = aluSltu;
				endcase
			end
			opAndi, opOri, opXori: begin
				rfWr = 1'b1;
				case (op)
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					default: aluOp = aluXor;
				endcase
			end
			opLui: begin
				// rs is zero in LUI, so OR passes the shifted immediate
				rfWr = 1'b1;
				aluOp = aluOr;
				extOp = extUpper;
			end
			opLb, opLbu, opLh, opLhu, opLw, opLwl, opLwr, opLl: begin
				rfWr = 1'b1;
				wbSel = wbMem;
				aluOp = aluAdd;
				extOp = extSign;
			end
			opSb, opSh, opSw, opSwl, opSwr: begin
				aluOp = aluAdd;
				extOp = extSign;
			end
			opSc: begin
				// success flag goes back to rt
				rfWr = 1'b1;
				wbSel = wbSc;
				aluOp = aluAdd;
				extOp = extSign;
			end
			opJal: begin
				rfWr = 1'b1;
				regDst = dstRa;
				wbSel = wbLink;
			end
			opRegImm: begin
				if (linkBranch) begin
					rfWr = 1'b1;
					regDst = dstRa;
					wbSel = wbLink;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: src/idCtrlPkg.sv
package idCtrlPkg;

	// primary opcodes
	localparam logic [5:0] opRType  = 6'b000000;
	localparam logic [5:0] opRegImm = 6'b000001;
	localparam logic [5:0] opJ      = 6'b000010;
	localparam logic [5:0] opJal    = 6'b000011;
	localparam logic [5:0] opBeq    = 6'b000100;
	localparam logic [5:0] opBne    = 6'b000101;
	localparam logic [5:0] opBlez   = 6'b000110;
	localparam logic [5:0] opBgtz   = 6'b000111;
	localparam logic [5:0] opAddi   = 6'b001000;
	localparam logic [5:0] opAddiu  = 6'b001001;
	localparam logic [5:0] opSlti   = 6'b001010;
	localparam logic [5:0] opSltiu  = 6'b001011;
	localparam logic [5:0] opAndi   = 6'b001100;
	localparam logic [5:0] opOri    = 6'b001101;
	localparam logic [5:0] opXori   = 6'b001110;
	localparam logic [5:0] opLui    = 6'b001111;
	localparam logic [5:0] opBeql   = 6'b010100;
	localparam logic [5:0] opBnel   = 6'b010101;
	localparam logic [5:0] opBlezl  = 6'b010110;
	localparam logic [5:0] opBgtzl  = 6'b010111;
	localparam logic [5:0] opLb     = 6'b100000;
	localparam logic [5:0] opLh     = 6'b100001;
	localparam logic [5:0] opLwl    = 6'b100010;
	localparam logic [5:0] opLw     = 6'b100011;
	localparam logic [5:0] opLbu    = 6'b100100;
	localparam logic [5:0] opLhu    = 6'b100101;
	localparam logic [5:0] opLwr    = 6'b100110;
	localparam logic [5:0] opSb     = 6'b101000;
	localparam logic [5:0] opSh     = 6'b101001;
	localparam logic [5:0] opSwl    = 6'b101010;
	localparam logic [5:0] opSw     = 6'b101011;
	localparam logic [5:0] opSwr    = 6'b101110;
	localparam logic [5:0] opLl     = 6'b110000;
	localparam logic [5:0] opSc     = 6'b111000;

	// SPECIAL function field
	localparam logic [5:0] fnSll     = 6'b000000;
	localparam logic [5:0] fnSrl     = 6'b000010;
	localparam logic [5:0] fnSra     = 6'b000011;
	localparam logic [5:0] fnSllv    = 6'b000100;
	localparam logic [5:0] fnSrlv    = 6'b000110;
	localparam logic [5:0] fnSrav    = 6'b000111;
	localparam logic [5:0] fnJr      = 6'b001000;
	localparam logic [5:0] fnJalr    = 6'b001001;
	localparam logic [5:0] fnSyscall = 6'b001100;
	localparam logic [5:0] fnBreak   = 6'b001101;
	localparam logic [5:0] fnAdd     = 6'b100000;
	localparam logic [5:0] fnAddu    = 6'b100001;
	localparam logic [5:0] fnSub     = 6'b100010;
	localparam logic [5:0] fnSubu    = 6'b100011;
	localparam logic [5:0] fnAnd     = 6'b100100;
	localparam logic [5:0] fnOr      = 6'b100101;
	localparam logic [5:0] fnXor     = 6'b100110;
	localparam logic [5:0] fnNor     = 6'b100111;
	localparam logic [5:0] fnSlt     = 6'b101010;
	localparam logic [5:0] fnSltu    = 6'b101011;

	// REGIMM rt field, bit 4 marks the linking forms and bit 1 the likely forms
	localparam logic [4:0] rtBltz    = 5'b00000;
	localparam logic [4:0] rtBgez    = 5'b00001;
	localparam logic [4:0] rtBltzl   = 5'b00010;
	localparam logic [4:0] rtBgezl   = 5'b00011;
	localparam logic [4:0] rtBltzal  = 5'b10000;
	localparam logic [4:0] rtBgezal  = 5'b10001;
	localparam logic [4:0] rtBltzall = 5'b10010;
	localparam logic [4:0] rtBgezall = 5'b10011;

	localparam logic [4:0] raReg = 5'd31;

	typedef enum logic [3:0] {
		aluAdd, aluAddu, aluSub, aluSubu, aluOr, aluAnd, aluNor, aluXor,
		aluSll, aluSrl, aluSra, aluSlt, aluSltu, aluNone
	} aluOpT;

	typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink, wbSc} wbSelT;
	typedef enum logic [2:0] {sizeByte, sizeByteU, sizeHalf, sizeHalfU, sizeWord} memSizeT;
	typedef enum logic [1:0] {partNone, partLeft, partRight} partialT;
	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcJumpReg} npcOpT;

	// comparator sign of rs, encoded as the datapath delivers it
	typedef enum logic [1:0] {
		signZero = 2'b00,
		signPos  = 2'b01,
		signNeg  = 2'b10
	} signClassT;

	typedef enum logic [1:0] {brNone, brReturn, brOther, brCall} brTypeT;
	typedef enum logic [1:0] {jNone, jDirect, jIndirect} jTypeT;

	// fetch codes arrive unchanged, so the code stays an open 5-bit value
	typedef logic [4:0] excCodeT;
	localparam excCodeT excNone     = 5'd0;
	localparam excCodeT excSyscall  = 5'd8;
	localparam excCodeT excBreak    = 5'd9;
	localparam excCodeT excReserved = 5'd10;

endpackage
